/* build.f */
+incdir+sim
verilog/rot_geom_pkg.sv
verilog/rot_ctrl_pkg.sv
verilog/weight_ingest.sv
verilog/weight_bank.sv
verilog/rotation_sequencer.sv
verilog/weight_rotator_top.sv
sim/tb_weight_rotator.sv

/* sim/tb_weight_table.svh */
// **************************************************************************
// Test case table of the weight rotator testbench: header fields, tail
// keep pattern, sink back-pressure mode and expected output beat count
// **************************************************************************
`ifndef TB_WEIGHT_TABLE_SVH
`define TB_WEIGHT_TABLE_SVH

localparam int BP_NONE  = 0;   // Sink always ready
localparam int BP_HALF  = 1;   // Ready on about half the cycles
localparam int BP_HEAVY = 2;   // Ready on about a quarter

string                  t_name     [$];
logic [BITS_KW2-1:0]    t_kw2      [$];
logic [BITS_CIN-1:0]    t_cin_1    [$];
logic [BITS_COLS-1:0]   t_cols_1   [$];
logic [BITS_BLOCKS-1:0] t_blocks_1 [$];
logic [BITS_XN-1:0]     t_xn_1     [$];
logic [1:0]             t_keep     [$];   // Keep bits of the tlast beat
int                     t_bp       [$];
int                     t_out      [$];   // Output beats incl. config beat

task automatic add_row(string name, int kw2, int cin_1, int cols_1, int blocks_1,
                       int xn_1, logic [1:0] keep, int bp, int out_beats);
  t_name.push_back(name);
  t_kw2.push_back(BITS_KW2'(kw2));
  t_cin_1.push_back(BITS_CIN'(cin_1));
  t_cols_1.push_back(BITS_COLS'(cols_1));
  t_blocks_1.push_back(BITS_BLOCKS'(blocks_1));
  t_xn_1.push_back(BITS_XN'(xn_1));
  t_keep.push_back(keep);
  t_bp.push_back(bp);
  t_out.push_back(out_beats);
endtask

task automatic load_table();
  // name               kw2 cin cols blk xn  tail   back-pressure  beats
  add_row("single_word",      0,  0,  0,  0, 0, 2'b01, BP_NONE,    2);
  add_row("k3_even_cols3",    1,  1,  2,  0, 0, 2'b11, BP_NONE,   19);
  add_row("k3_odd_heavy",     1,  2,  1,  1, 0, 2'b01, BP_HEAVY,  37);
  add_row("k5_batch_half",    2,  3,  3,  0, 1, 2'b11, BP_HALF,  161);
  add_row("k7_odd_blocks",    3,  4,  0,  2, 0, 2'b01, BP_HALF,  106);
  add_row("k3_repeat_ready",  1,  0,  3,  1, 1, 2'b01, BP_NONE,   49);
  add_row("k3_odd_ready",     1,  2,  1,  1, 0, 2'b01, BP_NONE,   37);
  add_row("k7_wide_cin",      3, 15,  1,  0, 0, 2'b11, BP_HALF,  225);
endtask

`endif

/* sim/tb_weight_rotator.sv */
// **************************************************************************
// Testbench of the weight rotator with clock and reset, table driven
// packet stimulus, reference model of the output beats, compare tasks
// and timeout
// **************************************************************************
`default_nettype none

module tb_weight_rotator
  import rot_geom_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [BITS_KW2+3:0] sideband_t;   // {is_config, kw2, w_first, cin_last, w_last}

  logic                    aclk = 1'b0;
  logic                    aresetn;
  logic                    i_s_tvalid;
  logic                    o_s_tready;
  logic [S_WIDTH-1:0]      i_s_tdata;
  logic [S_KEEP_WIDTH-1:0] i_s_tkeep;
  logic                    i_s_tlast;
  logic                    o_m_tvalid;
  logic                    i_m_tready;
  logic [M_WIDTH-1:0]      o_m_tdata;
  logic                    o_m_tlast;
  logic                    o_m_is_config;
  logic [BITS_KW2-1:0]     o_m_kw2;
  logic                    o_m_w_first;
  logic                    o_m_cin_last;
  logic                    o_m_w_last;

  // Input beats of all packets in send order
  logic [S_WIDTH-1:0]      in_data  [$];
  logic [S_KEEP_WIDTH-1:0] in_keep  [$];
  logic                    in_last  [$];
  // Expected output beats and the table row of each
  logic [M_WIDTH-1:0]      exp_data [$];
  sideband_t               exp_sb   [$];
  logic                    exp_last [$];
  int                      exp_row  [$];

  int cycle_count = 0;
  int cycle_limit = 0;

  `include "tb_weight_table.svh"

  weight_rotator_top i_weight_rotator_top (.*);

  always #20 aclk = !aclk;

  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the packets did not complete within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  task automatic stop_with_failure(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_data(string name, logic [M_WIDTH-1:0] exp, logic [M_WIDTH-1:0] act);
    if (exp !== act)
      stop_with_failure($sformatf("error %s data expected %h actual %h", name, exp, act));
  endtask

  task automatic check_sideband(string name, sideband_t exp, sideband_t act);
    if (exp !== act)
      stop_with_failure($sformatf("error %s sideband expected %b actual %b", name, exp, act));
  endtask

  task automatic check_last(string name, logic exp, logic act);
    if (exp !== act)
      stop_with_failure($sformatf("error %s tlast expected %b actual %b", name, exp, act));
  endtask

  function automatic logic [M_WIDTH-1:0] header_word(int row, int n_words);
    logic [M_WIDTH-1:0] hdr;
    hdr = '0;
    hdr[HDR_KW2_LSB      +: BITS_KW2]    = t_kw2[row];
    hdr[HDR_CIN_LSB      +: BITS_CIN]    = t_cin_1[row];
    hdr[HDR_COLS_LSB     +: BITS_COLS]   = t_cols_1[row];
    hdr[HDR_BLOCKS_LSB   +: BITS_BLOCKS] = t_blocks_1[row];
    hdr[HDR_XN_LSB       +: BITS_XN]     = t_xn_1[row];
    hdr[HDR_ADDR_MAX_LSB +: BITS_ADDR]   = BITS_ADDR'(n_words);   // Last weight address
    return hdr;
  endfunction

  function automatic logic pick_ready(int mode);
    if (mode == BP_HALF) return $urandom % 2 == 0;
    if (mode == BP_HEAVY) return $urandom % 4 == 0;
    return 1'b1;
  endfunction

  // Reference model builds the input beats of one packet and the beats it must produce
  task automatic build_packet(int row, inout int in_beats);
    logic [M_WIDTH-1:0] words [$];
    logic [M_WIDTH-1:0] hdr;
    logic [M_WIDTH-1:0] high;
    int                 n;
    int                 cols;
    int                 passes;
    logic               first;
    n      = (2 * int'(t_kw2[row]) + 1) * (int'(t_cin_1[row]) + 1);
    cols   = int'(t_cols_1[row]) + 1;
    passes = cols * (int'(t_blocks_1[row]) + 1) * (int'(t_xn_1[row]) + 1);
    hdr    = header_word(row, n);
    in_data.push_back({M_WIDTH'($urandom), hdr});   // Upper half is ignored
    in_keep.push_back(2'b11);
    in_last.push_back(1'b0);
    for (int i = 0; i < n; i++) words.push_back(M_WIDTH'($urandom));
    for (int i = 0; i < n; i += 2) begin
      high = (i + 1 < n) ? words[i + 1] : M_WIDTH'($urandom);
      in_data.push_back({high, words[i]});
      in_keep.push_back((i + 1 < n) ? 2'b11 : 2'b01);
      in_last.push_back(i + 2 >= n);
    end
    in_beats += 1 + (n + 1) / 2;
    if (in_keep[in_keep.size() - 1] !== t_keep[row])
      stop_with_failure($sformatf("table row %s has a tail keep that does not fit %0d words",
                                  t_name[row], n));
    if (1 + n * passes != t_out[row])
      stop_with_failure($sformatf("table row %s expects %0d beats but the model gives %0d",
                                  t_name[row], t_out[row], 1 + n * passes));

    exp_data.push_back(hdr);
    exp_sb.push_back({1'b1, t_kw2[row], 3'b000});
    exp_last.push_back(1'b0);
    exp_row.push_back(row);
    for (int p = 0; p < passes; p++) begin
      for (int j = 0; j < n; j++) begin
        first = (j == 0) && (p % cols == 0);
        exp_data.push_back(words[j]);
        exp_sb.push_back({1'b0, t_kw2[row], first, j == n - 1, p % cols == cols - 1});
        exp_last.push_back(p == passes - 1 && j == n - 1);
        exp_row.push_back(row);
      end
    end
  endtask

  // Beat leaves at the next rising edge when ready is seen here
  task automatic run_source();
    while (in_data.size() > 0) begin
      @(negedge aclk);
      i_s_tvalid = 1'b1;
      i_s_tdata  = in_data[0];
      i_s_tkeep  = in_keep[0];
      i_s_tlast  = in_last[0];
      if (o_s_tready) begin
        void'(in_data.pop_front());
        void'(in_keep.pop_front());
        void'(in_last.pop_front());
      end
    end
    @(negedge aclk);
    i_s_tvalid = 1'b0;
    i_s_tlast  = 1'b0;
  endtask

  task automatic run_sink();
    int        row;
    sideband_t act_sb;
    while (exp_data.size() > 0) begin
      @(negedge aclk);
      row        = exp_row[0];
      i_m_tready = pick_ready(t_bp[row]);
      if (o_m_tvalid && i_m_tready) begin
        act_sb = {o_m_is_config, o_m_kw2, o_m_w_first, o_m_cin_last, o_m_w_last};
        check_data(t_name[row], exp_data.pop_front(), o_m_tdata);
        check_sideband(t_name[row], exp_sb.pop_front(), act_sb);
        check_last(t_name[row], exp_last.pop_front(), o_m_tlast);
        void'(exp_row.pop_front());
      end
    end
  endtask

  initial begin
    int in_beats;
    int out_beats;
    aresetn    = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tkeep  = '0;
    i_s_tlast  = 1'b0;
    i_m_tready = 1'b0;
    in_beats   = 0;
    out_beats  = 0;
    void'($urandom(32'ha248_230c));

    load_table();
    for (int r = 0; r < t_name.size(); r++) begin
      build_packet(r, in_beats);
      out_beats += t_out[r];
    end
    cycle_limit = 4 * (in_beats + out_beats) + 200;

    repeat (2) @(negedge aclk);
    aresetn = 1'b1;
    if (o_m_tvalid !== 1'b0) stop_with_failure("o_m_tvalid is not low right after reset");

    // Packets go in back to back so one bank fills while the other drains
    fork
      run_source();
      run_sink();
    join

    repeat (10) begin
      @(negedge aclk);
      if (o_m_tvalid !== 1'b0)
        stop_with_failure("an extra output beat came after the last packet");
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/rot_ctrl_pkg.sv */
// *************************************************************************
// State types of the weight rotator: ingest, bank and sequencer FSMs
// *************************************************************************
`default_nettype none

package rot_ctrl_pkg;

  typedef enum logic [2:0] {
    ING_IDLE,     // Waiting for the write bank to free up
    ING_HEADER,
    ING_LOW,      // Low word of each beat
    ING_HIGH,     // Held upper word
    ING_SWITCH
  } ingest_state_e;

  typedef enum logic [1:0] {
    BANK_FREE,
    BANK_FILLING,
    BANK_FULL,
    BANK_DRAINING
  } bank_state_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_CONFIG,   // Header goes out once
    SEQ_READ,
    SEQ_SWITCH
  } seq_state_e;

endpackage

`default_nettype wire

/* verilog/rot_geom_pkg.sv */
// *************************************************************************
// Geometry of the weight rotator: word, beat and bank sizes, widths
// of the loop counters and bit positions of the header fields
// *************************************************************************
`default_nettype none

package rot_geom_pkg;

  localparam int WORD_WIDTH   = 8;
  localparam int COLS         = 4;                   // Words per engine beat
  localparam int M_WIDTH      = WORD_WIDTH * COLS;
  localparam int S_WIDTH      = 2 * M_WIDTH;         // Input beat carries two words
  localparam int S_KEEP_WIDTH = S_WIDTH / M_WIDTH;   // One keep bit per half

  localparam int BANK_DEPTH   = 256;                 // Header slot plus weights
  localparam int BITS_ADDR    = $clog2(BANK_DEPTH);

  // Loop field widths
  localparam int KW_MAX       = 7;
  localparam int BITS_KW2     = $clog2((KW_MAX + 1) / 2);
  localparam int BITS_KW      = BITS_KW2 + 1;        // Holds 2*kw2
  localparam int BITS_CIN     = 4;
  localparam int BITS_COLS    = 4;
  localparam int BITS_BLOCKS  = 3;
  localparam int BITS_XN      = 3;

  // Header word layout, low bits first
  localparam int HDR_KW2_LSB      = 0;
  localparam int HDR_CIN_LSB      = HDR_KW2_LSB    + BITS_KW2;
  localparam int HDR_COLS_LSB     = HDR_CIN_LSB    + BITS_CIN;
  localparam int HDR_BLOCKS_LSB   = HDR_COLS_LSB   + BITS_COLS;
  localparam int HDR_XN_LSB       = HDR_BLOCKS_LSB + BITS_BLOCKS;
  localparam int HDR_ADDR_MAX_LSB = HDR_XN_LSB     + BITS_XN;  // Ends below M_WIDTH

endpackage

`default_nettype wire

/* verilog/rotation_sequencer.sv */
// *************************************************************************
// Rotation sequencer: drains the full bank, runs the kernel, channel,
// column, block and batch loops, and feeds the output stream through a
// two entry skid stage that absorbs the bank read latency
// *************************************************************************
`default_nettype none

module rotation_sequencer
  import rot_geom_pkg::*, rot_ctrl_pkg::*;
(
  input  wire logic                        aclk,
  input  wire logic                        aresetn,

  input  wire logic [1:0]                  i_full,
  input  wire logic [1:0][M_WIDTH-1:0]     i_rd_data,
  input  wire logic [1:0][BITS_KW2-1:0]    i_kw2,
  input  wire logic [1:0][BITS_CIN-1:0]    i_cin_1,
  input  wire logic [1:0][BITS_COLS-1:0]   i_cols_1,
  input  wire logic [1:0][BITS_BLOCKS-1:0] i_blocks_1,
  input  wire logic [1:0][BITS_XN-1:0]     i_xn_1,
  output logic      [1:0]                  o_rd_start,
  output logic      [1:0]                  o_rd_en,
  output logic      [1:0]                  o_rd_done,

  output logic                             o_m_tvalid,
  input  wire logic                        i_m_tready,
  output logic      [M_WIDTH-1:0]          o_m_tdata,
  output logic                             o_m_tlast,
  output logic                             o_m_is_config,
  output logic      [BITS_KW2-1:0]         o_m_kw2,
  output logic                             o_m_w_first,
  output logic                             o_m_cin_last,
  output logic                             o_m_w_last
);

  seq_state_e             state;
  seq_state_e             state_next;
  logic                   rd_bank;
  logic                   issue_done;   // Final read already issued
  logic [BITS_KW-1:0]     c_kw;
  logic [BITS_CIN-1:0]    c_cin;
  logic [BITS_COLS-1:0]   c_cols;
  logic [BITS_BLOCKS-1:0] c_blocks;
  logic [BITS_XN-1:0]     c_xn;
  logic                   l_kw, l_cin, l_cols, l_blocks, l_xn;
  logic                   last_all;
  logic                   issue;
  logic                   room;
  logic                   m_xfer;
  logic [4:0]             flags;        // {config, w_first, cin_last, w_last, tlast}
  logic [4:0]             pend_flags;
  logic                   pend;         // Read in flight, data lands this cycle
  logic [M_WIDTH-1:0]     skid_data  [2];
  logic [4:0]             skid_flags [2];
  logic                   skid_wr;
  logic                   skid_rd;
  logic [1:0]             skid_count;

  assign l_kw     = (c_kw     == {i_kw2[rd_bank], 1'b0});
  assign l_cin    = (c_cin    == i_cin_1[rd_bank]);
  assign l_cols   = (c_cols   == i_cols_1[rd_bank]);
  assign l_blocks = (c_blocks == i_blocks_1[rd_bank]);
  assign l_xn     = (c_xn     == i_xn_1[rd_bank]);
  assign last_all = l_kw && l_cin && l_cols && l_blocks && l_xn;

  assign m_xfer = o_m_tvalid && i_m_tready;
  // Stored plus in-flight words must stay within two after this cycle
  assign room   = (3'(skid_count) + 3'(pend)) < (3'd2 + 3'(m_xfer));

  always_comb begin
    state_next = state;
    issue      = 1'b0;
    flags      = '0;
    o_rd_start = '0;
    o_rd_done  = '0;

    unique case (state)
      SEQ_IDLE: begin
        if (i_full[rd_bank]) begin
          o_rd_start[rd_bank] = 1'b1;
          state_next          = SEQ_CONFIG;
        end
      end
      SEQ_CONFIG: begin
        issue = room;
        flags = 5'b10000;
        if (room) state_next = SEQ_READ;
      end
      SEQ_READ: begin
        issue = room && !issue_done;
        flags = {1'b0, c_kw == '0 && c_cin == '0 && c_cols == '0,
                 l_kw && l_cin, l_cols, last_all};
        if (m_xfer && o_m_tlast) state_next = SEQ_SWITCH;
      end
      SEQ_SWITCH: begin
        o_rd_done[rd_bank] = 1'b1;
        state_next         = SEQ_IDLE;
      end
      default: begin
        state_next = SEQ_IDLE;
      end
    endcase
  end

  always_comb begin
    o_rd_en          = '0;
    o_rd_en[rd_bank] = issue;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= SEQ_IDLE;
      rd_bank    <= 1'b0;
      issue_done <= 1'b0;
    end else begin
      state <= state_next;
      if (state == SEQ_SWITCH) begin
        rd_bank    <= !rd_bank;
        issue_done <= 1'b0;
      end else if (state == SEQ_READ && issue && last_all) begin
        issue_done <= 1'b1;
      end
    end
  end

  // Nested loop counters, one step per issued weight read
  always_ff @(posedge aclk) begin
    if (!aresetn || state == SEQ_IDLE) begin
      c_kw     <= '0;
      c_cin    <= '0;
      c_cols   <= '0;
      c_blocks <= '0;
      c_xn     <= '0;
    end else if (state == SEQ_READ && issue) begin
      c_kw <= l_kw ? '0 : c_kw + 1'b1;
      if (l_kw) begin
        c_cin <= l_cin ? '0 : c_cin + 1'b1;
        if (l_cin) begin
          c_cols <= l_cols ? '0 : c_cols + 1'b1;
          if (l_cols) begin
            c_blocks <= l_blocks ? '0 : c_blocks + 1'b1;
            if (l_blocks) c_xn <= l_xn ? '0 : c_xn + 1'b1;
          end
        end
      end
    end
  end

  // Skid stage control
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pend       <= 1'b0;
      skid_wr    <= 1'b0;
      skid_rd    <= 1'b0;
      skid_count <= '0;
    end else begin
      pend <= issue;
      if (pend) skid_wr <= !skid_wr;
      if (m_xfer) skid_rd <= !skid_rd;
      skid_count <= skid_count + 2'(pend) - 2'(m_xfer);
    end
  end

  always_ff @(posedge aclk) begin
    pend_flags <= flags;   // Flags wait out the read latency with the word
    if (pend) begin
      skid_data[skid_wr]  <= i_rd_data[rd_bank];
      skid_flags[skid_wr] <= pend_flags;
    end
  end

  assign o_m_tvalid = (skid_count != '0);
  assign o_m_tdata  = skid_data[skid_rd];
  assign {o_m_is_config, o_m_w_first, o_m_cin_last, o_m_w_last, o_m_tlast} =
         skid_flags[skid_rd];
  assign o_m_kw2    = i_kw2[rd_bank];   // Constant over a packet

endmodule

`default_nettype wire

/* verilog/weight_bank.sv */
// *************************************************************************
// One ping-pong weight bank: word memory with one cycle read latency,
// header register, write pointer, cyclic read pointer, fill/drain FSM
// *************************************************************************
`default_nettype none

module weight_bank
  import rot_geom_pkg::*, rot_ctrl_pkg::*;
(
  input  wire logic                   aclk,
  input  wire logic                   aresetn,

  input  wire logic                   i_wr_hdr,
  input  wire logic                   i_wr_en,
  input  wire logic                   i_wr_last,
  input  wire logic [M_WIDTH-1:0]     i_wr_data,
  output logic                        o_free,

  input  wire logic                   i_rd_start,
  input  wire logic                   i_rd_en,
  input  wire logic                   i_rd_done,
  output logic                        o_full,
  output logic      [M_WIDTH-1:0]     o_rd_data,

  output logic      [BITS_KW2-1:0]    o_kw2,
  output logic      [BITS_CIN-1:0]    o_cin_1,
  output logic      [BITS_COLS-1:0]   o_cols_1,
  output logic      [BITS_BLOCKS-1:0] o_blocks_1,
  output logic      [BITS_XN-1:0]     o_xn_1
);

  bank_state_e          state;
  logic [M_WIDTH-1:0]   mem [BANK_DEPTH];
  logic [M_WIDTH-1:0]   hdr_q;
  logic [BITS_ADDR-1:0] wr_ptr;
  logic [BITS_ADDR-1:0] wr_addr;
  logic [BITS_ADDR-1:0] rd_ptr;
  logic [BITS_ADDR-1:0] addr_max;

  assign addr_max = hdr_q[HDR_ADDR_MAX_LSB +: BITS_ADDR];
  assign wr_addr  = i_wr_hdr ? '0 : wr_ptr;   // Header lives in slot 0

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= BANK_FREE;
    end else begin
      unique case (state)
        BANK_FREE:     if (i_wr_hdr)   state <= BANK_FILLING;
        BANK_FILLING:  if (i_wr_last)  state <= BANK_FULL;
        BANK_FULL:     if (i_rd_start) state <= BANK_DRAINING;
        BANK_DRAINING: if (i_rd_done)  state <= BANK_FREE;
        default:                       state <= BANK_FREE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_wr_hdr) wr_ptr <= BITS_ADDR'(1);
      else if (i_wr_en) wr_ptr <= wr_ptr + 1'b1;

      // Weights cycle 1..addr_max, header slot only on the first read
      if (i_rd_start) rd_ptr <= '0;
      else if (i_rd_en) rd_ptr <= (rd_ptr == addr_max) ? BITS_ADDR'(1) : rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wr_hdr || i_wr_en) mem[wr_addr] <= i_wr_data;
    if (i_rd_en) o_rd_data <= mem[rd_ptr];
  end

  always_ff @(posedge aclk) begin
    if (i_wr_hdr) hdr_q <= i_wr_data;
  end

  assign o_free = (state == BANK_FREE);
  assign o_full = (state == BANK_FULL);

  // Loop bounds for the sequencer
  assign o_kw2      = hdr_q[HDR_KW2_LSB    +: BITS_KW2];
  assign o_cin_1    = hdr_q[HDR_CIN_LSB    +: BITS_CIN];
  assign o_cols_1   = hdr_q[HDR_COLS_LSB   +: BITS_COLS];
  assign o_blocks_1 = hdr_q[HDR_BLOCKS_LSB +: BITS_BLOCKS];
  assign o_xn_1     = hdr_q[HDR_XN_LSB     +: BITS_XN];

endmodule

`default_nettype wire

/* verilog/weight_ingest.sv */
// *************************************************************************
// Weight stream ingest: takes the header beat, splits each wide weight
// beat into one or two words and steers the writes to the ping-pong bank
// *************************************************************************
`default_nettype none

module weight_ingest
  import rot_geom_pkg::*, rot_ctrl_pkg::*;
(
  input  wire logic                    aclk,
  input  wire logic                    aresetn,

  input  wire logic                    i_s_tvalid,
  output logic                         o_s_tready,
  input  wire logic [S_WIDTH-1:0]      i_s_tdata,
  input  wire logic [S_KEEP_WIDTH-1:0] i_s_tkeep,
  input  wire logic                    i_s_tlast,

  input  wire logic [1:0]              i_free,
  output logic      [1:0]              o_wr_hdr,
  output logic      [1:0]              o_wr_en,
  output logic      [1:0]              o_wr_last,
  output logic      [M_WIDTH-1:0]      o_wr_data
);

  ingest_state_e      state;
  ingest_state_e      state_next;
  logic               wr_bank;      // Bank being filled
  logic [M_WIDTH-1:0] high_q;       // Upper half of the last beat
  logic               last_q;       // That beat closed the packet
  logic               s_xfer;
  logic               hdr_pulse;
  logic               word_pulse;
  logic               last_pulse;

  assign s_xfer = i_s_tvalid && o_s_tready;

  always_comb begin
    state_next = state;
    o_s_tready = 1'b0;
    hdr_pulse  = 1'b0;
    word_pulse = 1'b0;
    last_pulse = 1'b0;

    unique case (state)
      ING_IDLE: begin
        if (i_free[wr_bank]) state_next = ING_HEADER;
      end
      ING_HEADER: begin
        o_s_tready = i_free[wr_bank];
        if (s_xfer) begin
          hdr_pulse  = 1'b1;
          state_next = ING_LOW;
        end
      end
      ING_LOW: begin
        o_s_tready = 1'b1;
        if (s_xfer) begin
          word_pulse = i_s_tkeep[0];
          if (i_s_tkeep[1]) begin
            state_next = ING_HIGH;     // Second word next cycle
          end else if (i_s_tlast) begin
            last_pulse = 1'b1;         // Odd word count ends on low half
            state_next = ING_SWITCH;
          end
        end
      end
      ING_HIGH: begin
        // Input stalls while the held word is written
        word_pulse = 1'b1;
        last_pulse = last_q;
        state_next = last_q ? ING_SWITCH : ING_LOW;
      end
      ING_SWITCH: begin
        state_next = ING_IDLE;
      end
      default: begin
        state_next = ING_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= ING_IDLE;
      wr_bank <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      state <= state_next;
      if (state == ING_SWITCH) wr_bank <= !wr_bank;
      if (state == ING_LOW && s_xfer) last_q <= i_s_tlast;
    end
  end

  always_ff @(posedge aclk) begin
    if (state == ING_LOW && s_xfer) high_q <= i_s_tdata[S_WIDTH-1:M_WIDTH];
  end

  // Strobes go to the selected bank only
  always_comb begin
    o_wr_hdr           = '0;
    o_wr_en            = '0;
    o_wr_last          = '0;
    o_wr_hdr[wr_bank]  = hdr_pulse;
    o_wr_en[wr_bank]   = word_pulse;
    o_wr_last[wr_bank] = last_pulse;
  end

  // Header and low words come straight from the beat
  assign o_wr_data = (state == ING_HIGH) ? high_q : i_s_tdata[M_WIDTH-1:0];

endmodule

`default_nettype wire

/* verilog/weight_rotator_top.sv */
// *************************************************************************
// Weight rotator top: ingest, two ping-pong weight banks and the
// rotation sequencer
// *************************************************************************
`default_nettype none

module weight_rotator_top
  import rot_geom_pkg::*;
(
  input  wire logic                    aclk,
  input  wire logic                    aresetn,

  input  wire logic                    i_s_tvalid,
  output logic                         o_s_tready,
  input  wire logic [S_WIDTH-1:0]      i_s_tdata,
  input  wire logic [S_KEEP_WIDTH-1:0] i_s_tkeep,
  input  wire logic                    i_s_tlast,

  output logic                         o_m_tvalid,
  input  wire logic                    i_m_tready,
  output logic      [M_WIDTH-1:0]      o_m_tdata,
  output logic                         o_m_tlast,
  output logic                         o_m_is_config,
  output logic      [BITS_KW2-1:0]     o_m_kw2,
  output logic                         o_m_w_first,
  output logic                         o_m_cin_last,
  output logic                         o_m_w_last
);

  logic [1:0]                  wr_hdr, wr_en, wr_last, free;
  logic [M_WIDTH-1:0]          wr_data;
  logic [1:0]                  rd_start, rd_en, rd_done, full;
  logic [1:0][M_WIDTH-1:0]     rd_data;
  logic [1:0][BITS_KW2-1:0]    kw2;
  logic [1:0][BITS_CIN-1:0]    cin_1;
  logic [1:0][BITS_COLS-1:0]   cols_1;
  logic [1:0][BITS_BLOCKS-1:0] blocks_1;
  logic [1:0][BITS_XN-1:0]     xn_1;

  weight_ingest i_weight_ingest (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .i_s_tdata  (i_s_tdata),
    .i_s_tkeep  (i_s_tkeep),
    .i_s_tlast  (i_s_tlast),
    .i_free     (free),
    .o_wr_hdr   (wr_hdr),
    .o_wr_en    (wr_en),
    .o_wr_last  (wr_last),
    .o_wr_data  (wr_data)
  );

  // Ping-pong pair
  generate
    for (genvar b = 0; b < 2; b++) begin : g_bank
      weight_bank i_weight_bank (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_hdr   (wr_hdr[b]),
        .i_wr_en    (wr_en[b]),
        .i_wr_last  (wr_last[b]),
        .i_wr_data  (wr_data),
        .o_free     (free[b]),
        .i_rd_start (rd_start[b]),
        .i_rd_en    (rd_en[b]),
        .i_rd_done  (rd_done[b]),
        .o_full     (full[b]),
        .o_rd_data  (rd_data[b]),
        .o_kw2      (kw2[b]),
        .o_cin_1    (cin_1[b]),
        .o_cols_1   (cols_1[b]),
        .o_blocks_1 (blocks_1[b]),
        .o_xn_1     (xn_1[b])
      );
    end
  endgenerate

  rotation_sequencer i_rotation_sequencer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_full        (full),
    .i_rd_data     (rd_data),
    .i_kw2         (kw2),
    .i_cin_1       (cin_1),
    .i_cols_1      (cols_1),
    .i_blocks_1    (blocks_1),
    .i_xn_1        (xn_1),
    .o_rd_start    (rd_start),
    .o_rd_en       (rd_en),
    .o_rd_done     (rd_done),
    .o_m_tvalid    (o_m_tvalid),
    .i_m_tready    (i_m_tready),
    .o_m_tdata     (o_m_tdata),
    .o_m_tlast     (o_m_tlast),
    .o_m_is_config (o_m_is_config),
    .o_m_kw2       (o_m_kw2),
    .o_m_w_first   (o_m_w_first),
    .o_m_cin_last  (o_m_cin_last),
    .o_m_w_last    (o_m_w_last)
  );

endmodule

`default_nettype wire
